// ==== include/ws28xx_settings.svh ====
`ifndef WS28XX_SETTINGS_SVH
`define WS28XX_SETTINGS_SVH

// Bus address width.
// Bit 10 selects the pixel RAM, bits 9:2 the word and bits 3:2 the register.
`define WS28XX_A_WIDTH 11

// Bus data width, also the width of one pixel word.
`define WS28XX_D_WIDTH 32

// Number of pixel words, one per LED.
`define WS28XX_D_DEPTH 256

`endif

// ==== logic/ws28xx_bit_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ws28xx_bit_encoder (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  logic                run_i,
    input  ws28xx_pkg::phase_t  t0h_i,
    input  ws28xx_pkg::phase_t  t1h_i,
    input  ws28xx_pkg::period_t t0_period_i,
    input  ws28xx_pkg::period_t t1_period_i,

    input  logic                bit_load_i,
    input  logic                bit_value_i,
    output logic                bit_end_o,
    output logic                line_o
);
    import ws28xx_pkg::*;

    enc_state_t state_q;
    period_t    cnt_q;
    phase_t     high_q;
    period_t    period_q;
    logic       accept;

    // A load is taken only between bits.
    assign accept    = bit_load_i && ((state_q == enc_idle) || bit_end_o);
    assign bit_end_o = (state_q == enc_low) && (cnt_q == period_q);
    assign line_o    = run_i && (state_q == enc_high);

    always_ff @(posedge clk_i) begin
        if (accept) begin
            high_q   <= bit_value_i ? t1h_i : t0h_i;
            period_q <= bit_value_i ? t1_period_i : t0_period_i;
        end
    end

    // The counter runs from 1 on the first high cycle to the period on the last low cycle.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= enc_idle;
            cnt_q   <= '0;
        end else if (!run_i) begin
            state_q <= enc_idle;
            cnt_q   <= '0;
        end else if (accept) begin
            state_q <= enc_high;
            cnt_q   <= period_t'(1);
        end else begin
            case (state_q)
                enc_high: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == period_t'(high_q)) begin
                        state_q <= enc_low;
                    end
                end
                enc_low: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (bit_end_o) begin
                        state_q <= enc_idle;
                    end
                end
                default: state_q <= enc_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/ws28xx_frame_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ws28xx_settings.svh"

module ws28xx_frame_seq (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  run_i,
    input  logic                  start_i,
    output logic                  done_o,

    output ws28xx_pkg::pix_idx_t  ram_addr_o,
    input  ws28xx_pkg::bus_data_t ram_data_i,

    input  logic                  bit_end_i,
    output logic                  bit_load_o,
    output logic                  bit_value_o
);
    import ws28xx_pkg::*;

    localparam pix_idx_t LAST_IDX = pix_idx_t'(`WS28XX_D_DEPTH - 1);

    seq_state_t  state_q;
    pix_idx_t    idx_q;
    logic [23:0] shift_q;
    logic [4:0]  bits_left_q;
    logic        mark_q;
    logic        first_q;
    logic        advance;
    logic        word_empty;
    logic        frame_end;

    // When the current word is used up, the next bit comes straight from the prefetched word.
    assign word_empty  = (bits_left_q == 5'd0);
    assign advance     = (state_q == seq_send) && (first_q || bit_end_i);
    assign frame_end   = advance && word_empty && mark_q;
    assign bit_load_o  = advance && !frame_end;
    assign bit_value_o = word_empty ? ram_data_i[23] : shift_q[23];
    assign done_o      = !run_i || (state_q == seq_idle) || (state_q == seq_finish);
    assign ram_addr_o  = idx_q;

    always_ff @(posedge clk_i) begin
        if (bit_load_o) begin
            shift_q <= word_empty ? {ram_data_i[22:0], 1'b0} : {shift_q[22:0], 1'b0};
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= seq_idle;
            idx_q       <= '0;
            bits_left_q <= '0;
            mark_q      <= 1'b0;
            first_q     <= 1'b0;
        end else if (!run_i) begin
            state_q     <= seq_idle;
            idx_q       <= '0;
            bits_left_q <= '0;
            mark_q      <= 1'b0;
            first_q     <= 1'b0;
        end else begin
            first_q <= 1'b0;
            case (state_q)
                seq_idle: begin
                    if (start_i) begin
                        state_q <= seq_fetch;
                    end
                end
                // Pixel 0 settles on the RAM output here.
                seq_fetch: begin
                    state_q     <= seq_send;
                    first_q     <= 1'b1;
                    bits_left_q <= '0;
                    mark_q      <= 1'b0;
                end
                seq_send: begin
                    if (frame_end) begin
                        state_q <= seq_finish;
                        idx_q   <= '0;
                    end else if (advance && word_empty) begin
                        bits_left_q <= 5'd23;
                        mark_q      <= (ram_data_i[31:24] != 8'd0) || (idx_q == LAST_IDX);
                        idx_q       <= idx_q + 1'b1;
                    end else if (advance) begin
                        bits_left_q <= bits_left_q - 1'b1;
                    end
                end
                seq_finish: state_q <= seq_idle;
                default:    state_q <= seq_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/ws28xx_pixel_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ws28xx_settings.svh"

module ws28xx_pixel_ram (
    input  logic                  clk_i,

    input  ws28xx_pkg::lane_en_t  wr_lane_en_i,
    input  ws28xx_pkg::pix_idx_t  wr_addr_i,
    input  ws28xx_pkg::bus_data_t wr_data_i,

    input  ws28xx_pkg::pix_idx_t  rd_addr_i,
    output ws28xx_pkg::bus_data_t rd_data_o
);
    import ws28xx_pkg::*;

    bus_data_t mem [`WS28XX_D_DEPTH];

    // One enable per byte lane.
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < $bits(lane_en_t); i++) begin
            if (wr_lane_en_i[i]) begin
                mem[wr_addr_i][8*i +: 8] <= wr_data_i[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== logic/ws28xx_pkg.sv ====
`default_nettype none

`include "ws28xx_settings.svh"

package ws28xx_pkg;

    typedef logic [`WS28XX_A_WIDTH-1:0]         bus_addr_t;
    typedef logic [`WS28XX_D_WIDTH-1:0]         bus_data_t;
    typedef logic [$clog2(`WS28XX_D_DEPTH)-1:0] pix_idx_t;
    typedef logic [`WS28XX_D_WIDTH/8-1:0]       lane_en_t;

    // One timing field, and a full bit period made of two of them.
    typedef logic [7:0] phase_t;
    typedef logic [8:0] period_t;

    typedef enum logic [1:0] {
        reg_ctrl_0   = 2'd0,
        reg_ctrl_1   = 2'd1,
        reg_ctrl_2   = 2'd2,
        reg_reserved = 2'd3
    } reg_idx_t;

    typedef enum logic [1:0] {
        seq_idle,
        seq_fetch,
        seq_send,
        seq_finish
    } seq_state_t;

    typedef enum logic [1:0] {
        enc_idle,
        enc_high,
        enc_low
    } enc_state_t;

endpackage

`default_nettype wire

// ==== logic/ws28xx_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ws28xx_regs (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  wr_en_i,
    input  ws28xx_pkg::bus_addr_t wr_addr_i,
    input  ws28xx_pkg::bus_data_t wr_data_i,

    input  logic                  rd_en_i,
    input  ws28xx_pkg::bus_addr_t rd_addr_i,
    output ws28xx_pkg::bus_data_t rd_data_o,

    input  logic                  done_i,
    output logic                  core_run_o,
    output logic                  start_o,
    output ws28xx_pkg::phase_t    t0h_o,
    output ws28xx_pkg::phase_t    t1h_o,
    output ws28xx_pkg::period_t   t0_period_o,
    output ws28xx_pkg::period_t   t1_period_o,

    output ws28xx_pkg::lane_en_t  ram_lane_en_o,
    output ws28xx_pkg::pix_idx_t  ram_addr_o,
    output ws28xx_pkg::bus_data_t ram_data_o
);
    import ws28xx_pkg::*;

    // Byte 3 holds the end marker, bytes 2 to 0 the colour.
    localparam lane_en_t MARKER_LANES = 4'b1000;
    localparam lane_en_t COLOUR_LANES = 4'b0111;

    logic      run_q;
    logic      sync_q;
    logic      lane_sel_q;
    phase_t    t0h_q;
    phase_t    t0l_q;
    phase_t    t1h_q;
    phase_t    t1l_q;
    logic      reg_wr;
    logic      ram_wr;
    reg_idx_t  wr_idx;
    reg_idx_t  rd_idx;
    bus_data_t rd_mux;

    assign reg_wr = wr_en_i && !wr_addr_i[10];
    assign ram_wr = wr_en_i && wr_addr_i[10];
    assign wr_idx = reg_idx_t'(wr_addr_i[3:2]);
    assign rd_idx = reg_idx_t'(rd_addr_i[3:2]);

    assign core_run_o  = run_q;
    assign start_o     = sync_q;
    assign t0h_o       = t0h_q;
    assign t1h_o       = t1h_q;
    assign t0_period_o = period_t'(t0h_q) + period_t'(t0l_q);
    assign t1_period_o = period_t'(t1h_q) + period_t'(t1l_q);

    assign ram_lane_en_o = !ram_wr ? '0 : (lane_sel_q ? MARKER_LANES : COLOUR_LANES);
    assign ram_addr_o    = wr_addr_i[9:2];
    assign ram_data_o    = wr_data_i;

    // RAM addresses read back as zero.
    always_comb begin
        rd_mux = '0;
        if (!rd_addr_i[10]) begin
            case (rd_idx)
                reg_ctrl_0: rd_mux = {done_i, 30'd0, run_q};
                reg_ctrl_1: rd_mux = {30'd0, lane_sel_q, sync_q};
                reg_ctrl_2: rd_mux = {t1l_q, t1h_q, t0l_q, t0h_q};
                default:    rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q      <= 1'b0;
            sync_q     <= 1'b0;
            lane_sel_q <= 1'b0;
            t0h_q      <= '0;
            t0l_q      <= '0;
            t1h_q      <= '0;
            t1l_q      <= '0;
            rd_data_o  <= '0;
        end else begin
            if (rd_en_i) begin
                rd_data_o <= rd_mux;
            end
            if (reg_wr) begin
                case (wr_idx)
                    reg_ctrl_0: run_q <= wr_data_i[0];
                    reg_ctrl_1: begin
                        sync_q     <= wr_data_i[0];
                        lane_sel_q <= wr_data_i[1];
                    end
                    reg_ctrl_2: {t1l_q, t1h_q, t0l_q, t0h_q} <= wr_data_i;
                    default: ;
                endcase
            end else if (!done_i) begin
                // The frame has been taken, so the start request is dropped.
                sync_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/ws28xx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ws28xx_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,

    input  logic                  wr_en_i,
    input  ws28xx_pkg::bus_addr_t wr_addr_i,
    input  ws28xx_pkg::bus_data_t wr_data_i,

    input  logic                  rd_en_i,
    input  ws28xx_pkg::bus_addr_t rd_addr_i,
    output ws28xx_pkg::bus_data_t rd_data_o,

    output logic                  ws28xx_o
);
    import ws28xx_pkg::*;

    logic      core_run;
    logic      start;
    logic      done;
    phase_t    t0h;
    phase_t    t1h;
    period_t   t0_period;
    period_t   t1_period;
    lane_en_t  ram_lane_en;
    pix_idx_t  ram_wr_addr;
    bus_data_t ram_wr_data;
    pix_idx_t  ram_rd_addr;
    bus_data_t ram_rd_data;
    logic      bit_load;
    logic      bit_value;
    logic      bit_end;

    ws28xx_regs i_regs (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wr_en_i       (wr_en_i),
        .wr_addr_i     (wr_addr_i),
        .wr_data_i     (wr_data_i),
        .rd_en_i       (rd_en_i),
        .rd_addr_i     (rd_addr_i),
        .rd_data_o     (rd_data_o),
        .done_i        (done),
        .core_run_o    (core_run),
        .start_o       (start),
        .t0h_o         (t0h),
        .t1h_o         (t1h),
        .t0_period_o   (t0_period),
        .t1_period_o   (t1_period),
        .ram_lane_en_o (ram_lane_en),
        .ram_addr_o    (ram_wr_addr),
        .ram_data_o    (ram_wr_data)
    );

    ws28xx_pixel_ram i_pixel_ram (
        .clk_i        (clk_i),
        .wr_lane_en_i (ram_lane_en),
        .wr_addr_i    (ram_wr_addr),
        .wr_data_i    (ram_wr_data),
        .rd_addr_i    (ram_rd_addr),
        .rd_data_o    (ram_rd_data)
    );

    ws28xx_frame_seq i_frame_seq (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .run_i       (core_run),
        .start_i     (start),
        .done_o      (done),
        .ram_addr_o  (ram_rd_addr),
        .ram_data_i  (ram_rd_data),
        .bit_end_i   (bit_end),
        .bit_load_o  (bit_load),
        .bit_value_o (bit_value)
    );

    ws28xx_bit_encoder i_bit_encoder (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .run_i       (core_run),
        .t0h_i       (t0h),
        .t1h_i       (t1h),
        .t0_period_i (t0_period),
        .t1_period_i (t1_period),
        .bit_load_i  (bit_load),
        .bit_value_i (bit_value),
        .bit_end_o   (bit_end),
        .line_o      (ws28xx_o)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the WS28xx testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module ws28xx_tb -f sim.f -o ws28xx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/ws28xx_sim +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

// ==== sim.f ====
+incdir+include
logic/ws28xx_pkg.sv
logic/ws28xx_regs.sv
logic/ws28xx_pixel_ram.sv
logic/ws28xx_frame_seq.sv
logic/ws28xx_bit_encoder.sv
logic/ws28xx_top.sv
test/ws28xx_props.sv
test/ws28xx_tb.sv

// ==== test/ws28xx_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module ws28xx_props (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  run_i,
    input  logic                  done_i,
    input  logic                  start_i,
    input  logic                  wr_en_i,
    input  ws28xx_pkg::phase_t    t0h_i,
    input  ws28xx_pkg::phase_t    t1h_i,
    input  logic                  rd_en_i,
    input  ws28xx_pkg::bus_data_t rd_data_i,
    input  logic                  line_i
);
    import ws28xx_pkg::*;

    int      fail_cnt = 0;
    period_t high_len;

    // Length of the current high pulse.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            high_len <= '0;
        end else if (line_i) begin
            high_len <= high_len + 1'b1;
        end else begin
            high_len <= '0;
        end
    end

    // A pulse cut short by the soft reset is exempt.
    pulse_width_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || !run_i)
        $fell(line_i) |-> (high_len == period_t'(t0h_i)) || (high_len == period_t'(t1h_i)))
    else begin
        fail_cnt++;
        $error("high pulse width matches neither t0h nor t1h");
    end

    done_line_low_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |-> !line_i)
    else begin
        fail_cnt++;
        $error("line high while done is set");
    end

    sync_clears_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (start_i && !done_i && !wr_en_i) |=> !start_i)
    else begin
        fail_cnt++;
        $error("sync stayed set while a frame runs");
    end

    read_data_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$stable(rd_data_i) |-> $past(rd_en_i))
    else begin
        fail_cnt++;
        $error("read data changed without a read");
    end

endmodule

bind ws28xx_top ws28xx_props i_props (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .run_i     (core_run),
    .done_i    (done),
    .start_i   (start),
    .wr_en_i   (wr_en_i),
    .t0h_i     (t0h),
    .t1h_i     (t1h),
    .rd_en_i   (rd_en_i),
    .rd_data_i (rd_data_o),
    .line_i    (ws28xx_o)
);

`default_nettype wire

// ==== test/ws28xx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ws28xx_tb;
    import ws28xx_pkg::*;

    localparam int T0H = 3;
    localparam int T0L = 7;
    localparam int T1H = 6;
    localparam int T1L = 5;
    localparam int NUM_PIX = 8;
    localparam int POLL_LIMIT = 2000;
    localparam int BIT_LIMIT = 5000;
    localparam int IDLE_WINDOW = 200;

    localparam bus_addr_t CTRL_0   = 11'h000;
    localparam bus_addr_t CTRL_1   = 11'h004;
    localparam bus_addr_t CTRL_2   = 11'h008;
    localparam bus_addr_t RESERVED = 11'h00C;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      wr_en;
    bus_addr_t wr_addr;
    bus_data_t wr_data;
    logic      rd_en;
    bus_addr_t rd_addr;
    bus_data_t rd_data;
    logic      line;

    int          mismatch_cnt = 0;
    int          timeout_cnt = 0;
    logic [31:0] lfsr = 32'h0d3a53d7;
    logic [23:0] colour [NUM_PIX];
    logic [7:0]  marker [NUM_PIX];
    bit          rx_bits [$];
    bit          exp_bits [$];
    logic        check_en = 1'b1;

    // Line decoder state.
    int   high_cnt = 0;
    int   low_cnt = 0;
    logic prev_line = 1'b0;
    logic pending = 1'b0;
    logic last_bit = 1'b0;

    ws28xx_top i_dut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .ws28xx_o  (line)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int low_time(input logic b);
        return b ? T1L : T0L;
    endfunction

    function automatic bus_addr_t pixel_addr(input int idx);
        return {1'b1, 8'(idx), 2'b00};
    endfunction

    task automatic report_mismatch(input string msg);
        mismatch_cnt++;
        $display("[FAIL] t=%0t %s", $time, msg);
    endtask

    task automatic check_value(input string what, input bus_data_t got, input bus_data_t exp);
        assert (got === exp)
        else report_mismatch($sformatf("%s read %08h, expected %08h", what, got, exp));
    endtask

    task automatic rand_colour(output logic [23:0] value);
        value = '0;
        for (int i = 0; i < 24; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[22:0], lfsr[0]};
        end
    endtask

    // Both bus tasks start and end on a falling edge.
    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        wr_en = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        rd_en = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        rd_en = 1'b0;
        data = rd_data;
    endtask

    task automatic set_lane_sel(input logic sel);
        bus_write(CTRL_1, {30'd0, sel, 1'b0});
    endtask

    task automatic wait_done(input logic level);
        bus_data_t val;
        int n = 0;
        bus_read(CTRL_0, val);
        while (val[31] !== level && n < POLL_LIMIT) begin
            bus_read(CTRL_0, val);
            n++;
        end
        if (val[31] !== level) begin
            timeout_cnt++;
            $display("Timeout: done flag did not reach %0d within %0d reads", level, POLL_LIMIT);
        end
    endtask

    task automatic wait_bits(input int count);
        int n = 0;
        while (rx_bits.size() < count && n < BIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        @(negedge clk);
        if (rx_bits.size() < count) begin
            timeout_cnt++;
            $display("Timeout: only %0d line bits seen, waited for %0d", rx_bits.size(), count);
        end
    endtask

    // Colour bits from pixel 0 up to and including the first marked pixel.
    task automatic build_expected();
        exp_bits.delete();
        for (int p = 0; p < NUM_PIX; p++) begin
            for (int b = 23; b >= 0; b--) begin
                exp_bits.push_back(colour[p][b]);
            end
            if (marker[p] != 8'd0) begin
                break;
            end
        end
    endtask

    task automatic start_frame();
        bus_data_t val;
        rx_bits.delete();
        build_expected();
        bus_write(CTRL_1, 32'h1);
        wait_done(1'b0);
        bus_read(CTRL_1, val);
        assert (val[0] == 1'b0) else report_mismatch("sync still reads 1 while the frame runs");
    endtask

    task automatic finish_frame(input int n_bits);
        wait_done(1'b1);
        // Window that catches any line activity after done.
        repeat (IDLE_WINDOW) @(negedge clk);
        assert (rx_bits.size() == n_bits)
        else report_mismatch($sformatf("frame had %0d bits, expected %0d", rx_bits.size(), n_bits));
        for (int i = 0; i < rx_bits.size() && i < exp_bits.size(); i++) begin
            assert (rx_bits[i] == exp_bits[i])
            else report_mismatch($sformatf("bit %0d is %0d, expected %0d",
                                           i, rx_bits[i], exp_bits[i]));
        end
    endtask

    // Decodes the line from the width of each high pulse.
    always @(negedge clk) begin
        if (!rst_n || i_dut.done) begin
            if (rst_n && pending && check_en) begin
                assert (low_cnt == low_time(last_bit))
                else report_mismatch($sformatf("last bit low for %0d cycles", low_cnt));
            end
            pending = 1'b0;
            high_cnt = 0;
            low_cnt = 0;
        end else if (line) begin
            if (!prev_line) begin
                if (pending) begin
                    assert (low_cnt == low_time(last_bit))
                    else report_mismatch($sformatf("bit low for %0d cycles", low_cnt));
                end
                high_cnt = 0;
            end
            high_cnt++;
        end else begin
            if (prev_line) begin
                assert (high_cnt == T0H || high_cnt == T1H)
                else report_mismatch($sformatf("high pulse of %0d cycles", high_cnt));
                last_bit = (high_cnt == T1H);
                rx_bits.push_back(last_bit);
                pending = 1'b1;
                low_cnt = 0;
            end
            low_cnt++;
        end
        prev_line = line;
    end

    initial begin
        bus_data_t val;
        int total;
        rst_n = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        assert (line == 1'b0) else report_mismatch("line not low after reset");
        bus_read(CTRL_0, val);
        check_value("ctrl_0 after reset", val, 32'h8000_0000);
        bus_read(CTRL_1, val);
        check_value("ctrl_1 after reset", val, 32'h0);
        bus_read(CTRL_2, val);
        check_value("ctrl_2 after reset", val, 32'h0);
        bus_read(RESERVED, val);
        check_value("reserved after reset", val, 32'h0);

        // Run is cleared again before sync is written, so no frame starts.
        bus_write(CTRL_0, '1);
        bus_read(CTRL_0, val);
        check_value("ctrl_0 all ones", val, 32'h8000_0001);
        bus_write(CTRL_0, '0);
        bus_write(CTRL_1, '1);
        bus_read(CTRL_1, val);
        check_value("ctrl_1 all ones", val, 32'h3);
        bus_write(CTRL_1, '0);
        bus_write(CTRL_2, '1);
        bus_read(CTRL_2, val);
        check_value("ctrl_2 all ones", val, '1);
        bus_write(RESERVED, '1);
        bus_read(RESERVED, val);
        check_value("reserved all ones", val, 32'h0);

        bus_write(CTRL_2, {8'(T1L), 8'(T1H), 8'(T0L), 8'(T0H)});
        set_lane_sel(1'b1);
        for (int p = 0; p < NUM_PIX; p++) begin
            marker[p] = (p == 4) ? 8'h80 : 8'h00;
            bus_write(pixel_addr(p), {marker[p], 24'h0});
        end
        // A nonzero top byte here would end the frame early if it reached the marker.
        set_lane_sel(1'b0);
        for (int p = 0; p < NUM_PIX; p++) begin
            rand_colour(colour[p]);
            bus_write(pixel_addr(p), {8'hFF, colour[p]});
        end
        bus_write(CTRL_0, 32'h1);
        start_frame();
        finish_frame(120);

        set_lane_sel(1'b1);
        marker[4] = 8'h00;
        bus_write(pixel_addr(4), 32'h0);
        marker[1] = 8'h5A;
        bus_write(pixel_addr(1), {marker[1], 24'h0});
        set_lane_sel(1'b0);
        for (int p = 0; p < 2; p++) begin
            rand_colour(colour[p]);
            bus_write(pixel_addr(p), {(p == 1) ? 8'h00 : 8'hFF, colour[p]});
        end
        start_frame();
        finish_frame(48);

        // Soft reset in the middle of a frame.
        start_frame();
        wait_bits(10);
        check_en = 1'b0;
        bus_write(CTRL_0, 32'h0);
        assert (line == 1'b0) else report_mismatch("line not low after run was cleared");
        bus_read(CTRL_0, val);
        check_value("ctrl_0 after soft reset", val, 32'h8000_0000);
        check_en = 1'b1;
        bus_write(CTRL_0, 32'h1);
        start_frame();
        finish_frame(48);

        total = mismatch_cnt + timeout_cnt + i_dut.i_props.fail_cnt;
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_cnt, timeout_cnt, i_dut.i_props.fail_cnt);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
